//--- verilog/axi4_lite_pkg.sv
package axi4_lite_pkg;

    // response codes returned on the b and r channels.
    // the encoding matches the AXI4-Lite bresp and rresp fields.
    typedef enum logic [1:0] {
        OKAY = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } response_t;

    // protection attributes carried on awprot and arprot.
    // bit 0 is privileged, bit 1 is non-secure and bit 2 marks an instruction access.
    // the register bank does not check them, they only travel through the crossing.
    typedef struct packed {
        logic instruction;
        logic non_secure;
        logic privileged;
    } access_t;

    // write path state of the register bank.
    // in idle the bank waits for an address and a data beat together.
    // in respond it holds bvalid until the master takes the response.
    typedef enum logic {
        idle = 1'b0,
        respond = 1'b1
    } bank_state_t;

endpackage

//--- verilog/axi4_lite_if.sv
`timescale 1ns/1ps

interface axi4_lite_if #(
    parameter int DATA_BYTES = 4,
    parameter int ADDRESS_WIDTH = 8
) ();
    import axi4_lite_pkg::*;

    // each strobe bit covers one byte of the data word.
    localparam int DATA_WIDTH = 8 * DATA_BYTES;

    // write address channel.
    logic awvalid;
    logic awready;
    logic [ADDRESS_WIDTH-1:0] awaddr;
    access_t awprot;

    // write data channel.
    logic wvalid;
    logic wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_BYTES-1:0] wstrb;

    // write response channel.
    logic bvalid;
    logic bready;
    response_t bresp;

    // read address channel.
    logic arvalid;
    logic arready;
    logic [ADDRESS_WIDTH-1:0] araddr;
    access_t arprot;

    // read data channel.
    logic rvalid;
    logic rready;
    logic [DATA_WIDTH-1:0] rdata;
    response_t rresp;

    // the master owns every valid and payload on the request channels.
    // it also owns the ready of the two response channels.
    modport master (
        output awvalid, awaddr, awprot, input awready,
        output wvalid, wdata, wstrb, input wready,
        input bvalid, bresp, output bready,
        output arvalid, araddr, arprot, input arready,
        input rvalid, rdata, rresp, output rready
    );

    // the slave side is the mirror image of the master side.
    modport slave (
        input awvalid, awaddr, awprot, output awready,
        input wvalid, wdata, wstrb, output wready,
        output bvalid, bresp, input bready,
        input arvalid, araddr, arprot, output arready,
        output rvalid, rdata, rresp, input rready
    );

endinterface

//--- verilog/gray_fifo_cdc.sv
`timescale 1ns/1ps

module gray_fifo_cdc #(
    parameter int WIDTH = 8,
    parameter int CAPACITY = 4
) (
    input logic reset,
    input logic rx_clk,
    input logic tx_clk,
    input logic rx_tvalid,
    output logic rx_tready,
    input logic [WIDTH-1:0] rx_tdata,
    output logic tx_tvalid,
    input logic tx_tready,
    output logic [WIDTH-1:0] tx_tdata
);
    // pointers carry one extra bit so that a full FIFO and an empty one differ.
    localparam int POINTER_WIDTH = $clog2(CAPACITY);

    // the FIFO is full when the gray write pointer equals the read pointer
    // with its two top bits inverted.
    localparam logic [POINTER_WIDTH:0] FULL_MASK = (POINTER_WIDTH + 1)'(3) << (POINTER_WIDTH - 1);

    logic [WIDTH-1:0] memory [CAPACITY];

    logic [POINTER_WIDTH:0] write_bin;
    logic [POINTER_WIDTH:0] write_bin_next;
    logic [POINTER_WIDTH:0] write_gray;
    logic [POINTER_WIDTH:0] write_gray_next;
    logic [POINTER_WIDTH:0] read_gray_meta;
    logic [POINTER_WIDTH:0] read_gray_sync;
    logic write_enable;
    logic full;

    logic [POINTER_WIDTH:0] read_bin;
    logic [POINTER_WIDTH:0] read_bin_next;
    logic [POINTER_WIDTH:0] read_gray;
    logic [POINTER_WIDTH:0] read_gray_next;
    logic [POINTER_WIDTH:0] write_gray_meta;
    logic [POINTER_WIDTH:0] write_gray_sync;
    logic read_enable;
    logic empty;

    // fill levels as each side sees them, only used by the checks below.
    logic [POINTER_WIDTH:0] rx_level;
    logic [POINTER_WIDTH:0] tx_level;

    function automatic logic [POINTER_WIDTH:0] gray_to_bin(input logic [POINTER_WIDTH:0] gray);
        logic [POINTER_WIDTH:0] bin;
        bin[POINTER_WIDTH] = gray[POINTER_WIDTH];
        for (int i = POINTER_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    // the sender may write whenever the registered full flag is clear.
    assign rx_tready = !full;
    assign write_enable = rx_tvalid && !full;
    assign write_bin_next = write_bin + {{POINTER_WIDTH{1'b0}}, write_enable};
    assign write_gray_next = (write_bin_next >> 1) ^ write_bin_next;

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            write_bin <= '0;
            write_gray <= '0;
            full <= 1'b0;
        end else begin
            write_bin <= write_bin_next;
            write_gray <= write_gray_next;
            full <= (write_gray_next == (read_gray_sync ^ FULL_MASK));
        end
    end

    // the read pointer reaches the write side through two flops.
    // only one bit of a gray pointer changes per step, so a half-captured
    // value is always either the old pointer or the new one.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            read_gray_meta <= '0;
            read_gray_sync <= '0;
        end else begin
            read_gray_meta <= read_gray;
            read_gray_sync <= read_gray_meta;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (write_enable) begin
            memory[write_bin[POINTER_WIDTH-1:0]] <= rx_tdata;
        end
    end

    // the oldest word is presented directly from the memory.
    // it was written at least two tx_clk edges before the empty flag clears.
    assign tx_tvalid = !empty;
    assign tx_tdata = memory[read_bin[POINTER_WIDTH-1:0]];
    assign read_enable = tx_tready && !empty;
    assign read_bin_next = read_bin + {{POINTER_WIDTH{1'b0}}, read_enable};
    assign read_gray_next = (read_bin_next >> 1) ^ read_bin_next;

    always_ff @(posedge tx_clk) begin
        if (reset) begin
            read_bin <= '0;
            read_gray <= '0;
            empty <= 1'b1;
        end else begin
            read_bin <= read_bin_next;
            read_gray <= read_gray_next;
            empty <= (read_gray_next == write_gray_sync);
        end
    end

    always_ff @(posedge tx_clk) begin
        if (reset) begin
            write_gray_meta <= '0;
            write_gray_sync <= '0;
        end else begin
            write_gray_meta <= write_gray;
            write_gray_sync <= write_gray_meta;
        end
    end

    assign rx_level = write_bin - gray_to_bin(read_gray_sync);
    assign tx_level = gray_to_bin(write_gray_sync) - read_bin;

    // a write must leave room even by the stale view of the read pointer.
    assert property (@(posedge rx_clk) disable iff (reset)
        rx_tvalid && rx_tready |-> rx_level < CAPACITY);

    // a read must find a word that the synchronized write pointer has passed.
    assert property (@(posedge tx_clk) disable iff (reset)
        tx_tvalid && tx_tready |-> tx_level != 0);

endmodule

//--- verilog/axi4_lite_clock_crossing.sv
`timescale 1ns/1ps

module axi4_lite_clock_crossing #(
    parameter int DATA_BYTES = 4,
    parameter int ADDRESS_WIDTH = 8,
    parameter int CAPACITY = 4
) (
    input logic reset,
    input logic slave_aclk,
    input logic master_aclk,
    axi4_lite_if.slave slave,
    axi4_lite_if.master master
);
    import axi4_lite_pkg::*;

    localparam int STRB_WIDTH = DATA_BYTES;
    localparam int DATA_WIDTH = 8 * DATA_BYTES;
    localparam int PROT_WIDTH = $bits(access_t);
    localparam int RESP_WIDTH = $bits(response_t);

    // the response words are split here so the enum fields get an explicit cast.
    logic [RESP_WIDTH-1:0] write_response_word;
    logic [RESP_WIDTH+DATA_WIDTH-1:0] read_data_word;

    // requests flow from the slave_aclk side to the master_aclk side.
    // the address and the prot bits travel as one FIFO word.
    gray_fifo_cdc #(
        .WIDTH(PROT_WIDTH + ADDRESS_WIDTH),
        .CAPACITY(CAPACITY)
    ) write_address_channel (
        .reset(reset),
        .rx_clk(slave_aclk),
        .tx_clk(master_aclk),
        .rx_tvalid(slave.awvalid),
        .rx_tready(slave.awready),
        .rx_tdata({slave.awprot, slave.awaddr}),
        .tx_tvalid(master.awvalid),
        .tx_tready(master.awready),
        .tx_tdata({master.awprot, master.awaddr})
    );

    // the data beat crosses on its own, so it may arrive before or after its address.
    gray_fifo_cdc #(
        .WIDTH(STRB_WIDTH + DATA_WIDTH),
        .CAPACITY(CAPACITY)
    ) write_data_channel (
        .reset(reset),
        .rx_clk(slave_aclk),
        .tx_clk(master_aclk),
        .rx_tvalid(slave.wvalid),
        .rx_tready(slave.wready),
        .rx_tdata({slave.wstrb, slave.wdata}),
        .tx_tvalid(master.wvalid),
        .tx_tready(master.wready),
        .tx_tdata({master.wstrb, master.wdata})
    );

    // responses run the other way, from the bank back to the external master.
    gray_fifo_cdc #(
        .WIDTH(RESP_WIDTH),
        .CAPACITY(CAPACITY)
    ) write_response_channel (
        .reset(reset),
        .rx_clk(master_aclk),
        .tx_clk(slave_aclk),
        .rx_tvalid(master.bvalid),
        .rx_tready(master.bready),
        .rx_tdata(master.bresp),
        .tx_tvalid(slave.bvalid),
        .tx_tready(slave.bready),
        .tx_tdata(write_response_word)
    );

    gray_fifo_cdc #(
        .WIDTH(PROT_WIDTH + ADDRESS_WIDTH),
        .CAPACITY(CAPACITY)
    ) read_address_channel (
        .reset(reset),
        .rx_clk(slave_aclk),
        .tx_clk(master_aclk),
        .rx_tvalid(slave.arvalid),
        .rx_tready(slave.arready),
        .rx_tdata({slave.arprot, slave.araddr}),
        .tx_tvalid(master.arvalid),
        .tx_tready(master.arready),
        .tx_tdata({master.arprot, master.araddr})
    );

    gray_fifo_cdc #(
        .WIDTH(RESP_WIDTH + DATA_WIDTH),
        .CAPACITY(CAPACITY)
    ) read_data_channel (
        .reset(reset),
        .rx_clk(master_aclk),
        .tx_clk(slave_aclk),
        .rx_tvalid(master.rvalid),
        .rx_tready(master.rready),
        .rx_tdata({master.rresp, master.rdata}),
        .tx_tvalid(slave.rvalid),
        .tx_tready(slave.rready),
        .tx_tdata(read_data_word)
    );

    assign slave.bresp = response_t'(write_response_word);
    assign slave.rresp = response_t'(read_data_word[DATA_WIDTH +: RESP_WIDTH]);
    assign slave.rdata = read_data_word[DATA_WIDTH-1:0];

endmodule

//--- verilog/axi4_lite_register_bank.sv
`timescale 1ns/1ps

module axi4_lite_register_bank #(
    parameter int DATA_BYTES = 4,
    parameter int ADDRESS_WIDTH = 8,
    parameter int REG_COUNT = 8
) (
    input logic reset,
    input logic aclk,
    axi4_lite_if.slave bus
);
    import axi4_lite_pkg::*;

    localparam int DATA_WIDTH = 8 * DATA_BYTES;

    // byte addresses are turned into word indices by dropping the byte offset.
    localparam int INDEX_SHIFT = $clog2(DATA_BYTES);

    // once the range check has passed, only the low index bits pick a register.
    localparam int INDEX_WIDTH = $clog2(REG_COUNT);

    logic [DATA_WIDTH-1:0] registers [REG_COUNT];

    bank_state_t write_state;
    logic [ADDRESS_WIDTH-1:0] write_index;
    logic write_hit;
    logic write_accept;
    response_t write_resp;

    logic [ADDRESS_WIDTH-1:0] read_index;
    logic read_hit;
    logic read_accept;
    logic read_pending;
    response_t read_resp;
    logic [DATA_WIDTH-1:0] read_data;

    assign write_index = bus.awaddr >> INDEX_SHIFT;
    assign write_hit = (write_index < REG_COUNT);
    assign read_index = bus.araddr >> INDEX_SHIFT;
    assign read_hit = (read_index < REG_COUNT);

    // address and data cross the clock boundary separately.
    // a write is only taken once both have arrived, and both are popped together.
    assign write_accept = (write_state == idle) && bus.awvalid && bus.wvalid;
    assign bus.awready = write_accept;
    assign bus.wready = write_accept;
    assign bus.bvalid = (write_state == respond);
    assign bus.bresp = write_resp;

    // the register contents are architectural state and read as zero after reset.
    always_ff @(posedge aclk) begin
        if (reset) begin
            write_state <= idle;
            for (int i = 0; i < REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else begin
            case (write_state)
                idle: begin
                    if (write_accept) begin
                        write_state <= respond;
                    end
                end
                respond: begin
                    if (bus.bready) begin
                        write_state <= idle;
                    end
                end
                default: write_state <= idle;
            endcase
            // only bytes with their strobe set are updated.
            if (write_accept && write_hit) begin
                for (int b = 0; b < DATA_BYTES; b++) begin
                    if (bus.wstrb[b]) begin
                        registers[write_index[INDEX_WIDTH-1:0]][8*b +: 8] <=
                            bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // a new read is taken only after the previous read data has been accepted.
    assign read_accept = bus.arvalid && !read_pending;
    assign bus.arready = read_accept;
    assign bus.rvalid = read_pending;
    assign bus.rdata = read_data;
    assign bus.rresp = read_resp;

    always_ff @(posedge aclk) begin
        if (reset) begin
            read_pending <= 1'b0;
        end else if (read_accept) begin
            read_pending <= 1'b1;
        end else if (bus.rready) begin
            read_pending <= 1'b0;
        end
    end

    // response payloads are captured with the request and held while valid is up.
    // an address beyond the bank decodes to DECERR and reads back as zero.
    always_ff @(posedge aclk) begin
        if (write_accept) begin
            write_resp <= write_hit ? OKAY : DECERR;
        end
        if (read_accept) begin
            read_resp <= read_hit ? OKAY : DECERR;
            read_data <= read_hit ? registers[read_index[INDEX_WIDTH-1:0]] : '0;
        end
    end

    // a response that is not taken stays on the bus unchanged for the next cycle.
    assert property (@(posedge aclk) disable iff (reset)
        bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

    assert property (@(posedge aclk) disable iff (reset)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rresp) && $stable(bus.rdata));

endmodule

//--- verilog/axi4_lite_cdc_top.sv
`timescale 1ns/1ps

module axi4_lite_cdc_top #(
    parameter int DATA_BYTES = 4,
    parameter int ADDRESS_WIDTH = 8,
    parameter int CAPACITY = 4,
    parameter int REG_COUNT = 8
) (
    input logic reset,
    input logic slave_aclk,
    input logic master_aclk,
    input logic s_awvalid,
    output logic s_awready,
    input logic [ADDRESS_WIDTH-1:0] s_awaddr,
    input axi4_lite_pkg::access_t s_awprot,
    input logic s_wvalid,
    output logic s_wready,
    input logic [8*DATA_BYTES-1:0] s_wdata,
    input logic [DATA_BYTES-1:0] s_wstrb,
    output logic s_bvalid,
    input logic s_bready,
    output axi4_lite_pkg::response_t s_bresp,
    input logic s_arvalid,
    output logic s_arready,
    input logic [ADDRESS_WIDTH-1:0] s_araddr,
    input axi4_lite_pkg::access_t s_arprot,
    output logic s_rvalid,
    input logic s_rready,
    output logic [8*DATA_BYTES-1:0] s_rdata,
    output axi4_lite_pkg::response_t s_rresp
);
    // slave_bus lives in the slave_aclk domain and master_bus in the master_aclk domain.
    axi4_lite_if #(
        .DATA_BYTES(DATA_BYTES),
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) slave_bus ();

    axi4_lite_if #(
        .DATA_BYTES(DATA_BYTES),
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) master_bus ();

    // the external master drives the request side of slave_bus.
    assign slave_bus.awvalid = s_awvalid;
    assign slave_bus.awaddr = s_awaddr;
    assign slave_bus.awprot = s_awprot;
    assign slave_bus.wvalid = s_wvalid;
    assign slave_bus.wdata = s_wdata;
    assign slave_bus.wstrb = s_wstrb;
    assign slave_bus.bready = s_bready;
    assign slave_bus.arvalid = s_arvalid;
    assign slave_bus.araddr = s_araddr;
    assign slave_bus.arprot = s_arprot;
    assign slave_bus.rready = s_rready;

    // handshakes and responses come back from the crossing.
    assign s_awready = slave_bus.awready;
    assign s_wready = slave_bus.wready;
    assign s_bvalid = slave_bus.bvalid;
    assign s_bresp = slave_bus.bresp;
    assign s_arready = slave_bus.arready;
    assign s_rvalid = slave_bus.rvalid;
    assign s_rdata = slave_bus.rdata;
    assign s_rresp = slave_bus.rresp;

    axi4_lite_clock_crossing #(
        .DATA_BYTES(DATA_BYTES),
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .CAPACITY(CAPACITY)
    ) crossing (
        .reset(reset),
        .slave_aclk(slave_aclk),
        .master_aclk(master_aclk),
        .slave(slave_bus.slave),
        .master(master_bus.master)
    );

    axi4_lite_register_bank #(
        .DATA_BYTES(DATA_BYTES),
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .REG_COUNT(REG_COUNT)
    ) bank (
        .reset(reset),
        .aclk(master_aclk),
        .bus(master_bus.slave)
    );

endmodule

//--- tests/tb_axi4_lite_cdc.sv
`timescale 1ns/1ps

module tb_axi4_lite_cdc;
    import axi4_lite_pkg::*;

    localparam int DATA_BYTES = 4;
    localparam int ADDRESS_WIDTH = 8;
    localparam int CAPACITY = 4;
    localparam int REG_COUNT = 8;
    localparam int DATA_WIDTH = 8 * DATA_BYTES;
    localparam int WAIT_LIMIT = 400;

    // test names and response names from the vectors file are held as packed text.
    typedef logic [8*24-1:0] label_t;

    logic reset;
    logic slave_aclk;
    logic master_aclk;
    logic s_awvalid;
    logic s_awready;
    logic [ADDRESS_WIDTH-1:0] s_awaddr;
    access_t s_awprot;
    logic s_wvalid;
    logic s_wready;
    logic [DATA_WIDTH-1:0] s_wdata;
    logic [DATA_BYTES-1:0] s_wstrb;
    logic s_bvalid;
    logic s_bready;
    response_t s_bresp;
    logic s_arvalid;
    logic s_arready;
    logic [ADDRESS_WIDTH-1:0] s_araddr;
    access_t s_arprot;
    logic s_rvalid;
    logic s_rready;
    logic [DATA_WIDTH-1:0] s_rdata;
    response_t s_rresp;

    int seed;
    int master_reset_edges;

    // queued writes wait here for their responses, oldest first.
    response_t pending_resp[$];
    label_t pending_label[$];

    axi4_lite_cdc_top #(
        .DATA_BYTES(DATA_BYTES),
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .CAPACITY(CAPACITY),
        .REG_COUNT(REG_COUNT)
    ) UUT (
        .reset(reset),
        .slave_aclk(slave_aclk),
        .master_aclk(master_aclk),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_awaddr(s_awaddr),
        .s_awprot(s_awprot),
        .s_wvalid(s_wvalid),
        .s_wready(s_wready),
        .s_wdata(s_wdata),
        .s_wstrb(s_wstrb),
        .s_bvalid(s_bvalid),
        .s_bready(s_bready),
        .s_bresp(s_bresp),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_araddr(s_araddr),
        .s_arprot(s_arprot),
        .s_rvalid(s_rvalid),
        .s_rready(s_rready),
        .s_rdata(s_rdata),
        .s_rresp(s_rresp)
    );

    // the two clocks have unrelated periods of 8 ns and 13 ns.
    always #4 slave_aclk = ~slave_aclk;
    always #6.5 master_aclk = ~master_aclk;

    // counts the master_aclk edges that see reset, so that domain is reset as well.
    always @(posedge master_aclk) begin
        if (reset) begin
            master_reset_edges <= master_reset_edges + 1;
        end
    end

    task automatic report_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input label_t label, input string what);
        $display("timed out in %0s while waiting for %0s", label, what);
        report_failure();
    endtask

    task automatic check_resp(input label_t label, input response_t expected,
                              input response_t actual);
        if (actual !== expected) begin
            $display("FAILED %0s expected %s actual %s", label, expected.name(), actual.name());
            report_failure();
        end
    endtask

    task automatic check_data(input label_t label, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %0s expected %h actual %h", label, expected, actual);
            report_failure();
        end
    endtask

    // address and data are offered together, and each drops after its own handshake.
    task automatic send_write(input label_t label, input logic [ADDRESS_WIDTH-1:0] addr,
                              input logic [DATA_BYTES-1:0] strb,
                              input logic [DATA_WIDTH-1:0] data);
        logic address_taken;
        logic data_taken;
        int cycles;
        address_taken = 1'b0;
        data_taken = 1'b0;
        cycles = 0;
        @(posedge slave_aclk);
        s_awvalid <= 1'b1;
        s_awaddr <= addr;
        s_wvalid <= 1'b1;
        s_wdata <= data;
        s_wstrb <= strb;
        while (!(address_taken && data_taken)) begin
            // ready is looked at mid cycle, where it holds its value for the coming edge.
            @(negedge slave_aclk);
            if (s_awvalid && s_awready) begin
                address_taken = 1'b1;
            end
            if (s_wvalid && s_wready) begin
                data_taken = 1'b1;
            end
            @(posedge slave_aclk);
            if (address_taken) begin
                s_awvalid <= 1'b0;
            end
            if (data_taken) begin
                s_wvalid <= 1'b0;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(label, "awready and wready");
            end
        end
    endtask

    task automatic send_read(input label_t label, input logic [ADDRESS_WIDTH-1:0] addr);
        logic taken;
        int cycles;
        taken = 1'b0;
        cycles = 0;
        @(posedge slave_aclk);
        s_arvalid <= 1'b1;
        s_araddr <= addr;
        while (!taken) begin
            @(negedge slave_aclk);
            taken = s_arvalid && s_arready;
            @(posedge slave_aclk);
            if (taken) begin
                s_arvalid <= 1'b0;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(label, "arready");
            end
        end
    endtask

    // bready is stalled at random so that responses back up inside the crossing.
    task automatic take_write_response(input label_t label, output response_t resp);
        logic taken;
        int cycles;
        taken = 1'b0;
        cycles = 0;
        while (!taken) begin
            @(posedge slave_aclk);
            s_bready <= (($random(seed) & 3) != 0);
            @(negedge slave_aclk);
            if (s_bvalid && s_bready) begin
                taken = 1'b1;
                resp = s_bresp;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(label, "bvalid");
            end
        end
        // the transfer happens on this edge, and bready falls right after it.
        @(posedge slave_aclk);
        s_bready <= 1'b0;
    endtask

    task automatic take_read_response(input label_t label, output response_t resp,
                                      output logic [DATA_WIDTH-1:0] data);
        logic taken;
        int cycles;
        taken = 1'b0;
        cycles = 0;
        while (!taken) begin
            @(posedge slave_aclk);
            s_rready <= (($random(seed) & 3) != 0);
            @(negedge slave_aclk);
            if (s_rvalid && s_rready) begin
                taken = 1'b1;
                resp = s_rresp;
                data = s_rdata;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(label, "rvalid");
            end
        end
        @(posedge slave_aclk);
        s_rready <= 1'b0;
    endtask

    // responses to queued writes must come back in the order the writes went out.
    task automatic drain_writes();
        response_t resp;
        while (pending_resp.size() > 0) begin
            take_write_response(pending_label[0], resp);
            check_resp(pending_label[0], pending_resp[0], resp);
            void'(pending_resp.pop_front());
            void'(pending_label.pop_front());
        end
    endtask

    task automatic decode_response(input label_t label, input label_t text,
                                   output response_t resp);
        if (text == label_t'("OKAY")) begin
            resp = OKAY;
        end else if (text == label_t'("EXOKAY")) begin
            resp = EXOKAY;
        end else if (text == label_t'("SLVERR")) begin
            resp = SLVERR;
        end else if (text == label_t'("DECERR")) begin
            resp = DECERR;
        end else begin
            $display("vector %0s names an unknown response %0s", label, text);
            report_failure();
        end
    endtask

    initial begin
        int fd;
        int fields;
        int cycles;
        logic reading;
        label_t label;
        label_t resp_text;
        logic [8*128-1:0] comment_text;
        logic [7:0] op_char;
        logic [ADDRESS_WIDTH-1:0] addr;
        logic [DATA_BYTES-1:0] strb;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] rdata;
        logic [DATA_WIDTH-1:0] data;
        response_t expected;
        response_t resp;

        seed = 35;
        master_reset_edges = 0;
        slave_aclk = 1'b0;
        master_aclk = 1'b0;
        reset = 1'b1;
        s_awvalid = 1'b0;
        s_awaddr = '0;
        s_awprot = '0;
        s_wvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_bready = 1'b0;
        s_arvalid = 1'b0;
        s_araddr = '0;
        s_arprot = '0;
        s_rready = 1'b0;

        // reset spans three slave_aclk cycles and at least three master_aclk edges.
        repeat (3) @(posedge slave_aclk);
        cycles = 0;
        while (master_reset_edges < 3) begin
            @(posedge slave_aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout(label_t'("reset"), "master_aclk edges");
            end
        end
        reset <= 1'b0;

        fd = $fopen("tests/axi4_lite_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/axi4_lite_vectors.txt");
            report_failure();
        end
        reading = 1'b1;
        while (reading) begin
            fields = $fscanf(fd, "%s", label);
            if (fields != 1) begin
                reading = 1'b0;
            end else if (label == label_t'("#")) begin
                fields = $fgets(comment_text, fd);
            end else begin
                fields = $fscanf(fd, " %s %h %h %h %s %h", op_char, addr, strb, wdata,
                                 resp_text, rdata);
                if (fields != 6) begin
                    $display("vector %0s does not have six fields after its name", label);
                    report_failure();
                end
                decode_response(label, resp_text, expected);
                if (op_char == "q") begin
                    // queued writes go out back to back and are answered later.
                    send_write(label, addr, strb, wdata);
                    pending_resp.push_back(expected);
                    pending_label.push_back(label);
                end else begin
                    drain_writes();
                    if (op_char == "w") begin
                        send_write(label, addr, strb, wdata);
                        take_write_response(label, resp);
                        check_resp(label, expected, resp);
                    end else if (op_char == "r") begin
                        send_read(label, addr);
                        take_read_response(label, resp, data);
                        check_resp(label, expected, resp);
                        check_data(label, rdata, data);
                    end else begin
                        $display("vector %0s has an unknown operation", label);
                        report_failure();
                    end
                end
            end
        end
        $fclose(fd);
        drain_writes();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- tests/axi4_lite_vectors.txt
# name op addr strb wdata resp rdata (op w is write, r is read, q is queued write; hex)
# queued writes are answered before the next w or r line, rdata only counts for reads
reset_read_reg0 r 00 0 00000000 OKAY 00000000
reset_read_reg7 r 1c 0 00000000 OKAY 00000000
full_write_reg1 w 04 f 12345678 OKAY 00000000
full_read_reg1 r 04 0 00000000 OKAY 12345678
partial_write_reg1_a w 04 5 aabbccdd OKAY 00000000
partial_read_reg1_a r 04 0 00000000 OKAY 12bb56dd
partial_write_reg1_b w 04 8 ee000000 OKAY 00000000
partial_read_reg1_b r 04 0 00000000 OKAY eebb56dd
decerr_write_reg8 w 20 f deadbeef DECERR 00000000
decerr_read_reg8 r 20 0 00000000 DECERR 00000000
decerr_read_top r fc 0 00000000 DECERR 00000000
unchanged_read_reg1 r 04 0 00000000 OKAY eebb56dd
unchanged_read_reg0 r 00 0 00000000 OKAY 00000000
queued_write_reg2 q 08 f 22222222 OKAY 00000000
queued_write_reg3 q 0c f 33333333 OKAY 00000000
queued_write_reg5 q 14 f 55555555 OKAY 00000000
queued_write_reg6 q 18 f 66666666 OKAY 00000000
queued_read_reg2 r 08 0 00000000 OKAY 22222222
queued_read_reg3 r 0c 0 00000000 OKAY 33333333
queued_read_reg5 r 14 0 00000000 OKAY 55555555
queued_read_reg6 r 18 0 00000000 OKAY 66666666

//--- tb.f
verilog/axi4_lite_pkg.sv
verilog/axi4_lite_if.sv
verilog/gray_fifo_cdc.sv
verilog/axi4_lite_clock_crossing.sv
verilog/axi4_lite_register_bank.sv
verilog/axi4_lite_cdc_top.sv
tests/tb_axi4_lite_cdc.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_axi4_lite_cdc
FLAGS ?= --binary --assert
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# builds the testbench and passes only when the run prints the pass message.
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f tb.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
